// ==== Bender.yml ====
package:
  name: tri_raster

sources:
  - logic/rast_pkg.sv
  - logic/tri_setup.sv
  - logic/edge_walker.sv
  - logic/span_walker.sv
  - logic/scan_ctrl.sv
  - logic/tri_raster.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_tri_raster.sv

// ==== logic/edge_walker.sv ====
`timescale 1ns/1ps
`default_nettype none

module edge_walker import rast_pkg::*; (
    input  logic      CLK,
    input  logic      RESET,
    input  logic      edge_load,
    input  logic      edge_step,
    input  vertex_t   from_v,
    input  vertex_t   to_v,
    output edge_pos_t pos
);

    // End rows, rounded up to whole pixels
    fixed_t y_lo, y_hi;

    // Deltas and slopes at double width
    logic signed [63:0] dx, dy, dz;
    logic signed [63:0] slope_x_w, slope_z_w;
    logic signed [63:0] pre_y;

    // Position at the first whole row
    fixed_t start_x, start_z;

    // Per-row increments
    fixed_t step_x, step_z;

    always_comb begin
        y_lo = (from_v.y + ONE_PIXEL - 1) & ~(ONE_PIXEL - 1);
        y_hi = (to_v.y + ONE_PIXEL - 1) & ~(ONE_PIXEL - 1);

        dx = 64'(to_v.x) - 64'(from_v.x);
        dy = 64'(to_v.y) - 64'(from_v.y);
        dz = 64'(to_v.z) - 64'(from_v.z);

        // Flat edge has no rows, slope is irrelevant
        if (dy == '0) begin
            slope_x_w = '0;
            slope_z_w = '0;
        end else begin
            slope_x_w = (dx * ONE_PIXEL) / dy;
            slope_z_w = (dz * ONE_PIXEL) / dy;
        end

        // Sub-pixel distance up to the first row centre line
        pre_y = 64'(y_lo) - 64'(from_v.y);
        start_x = from_v.x + fixed_t'((pre_y * slope_x_w) >>> FRAC_BITS);
        start_z = from_v.z + fixed_t'((pre_y * slope_z_w) >>> FRAC_BITS);
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            pos    <= '0;
            step_x <= '0;
            step_z <= '0;
        end else if (edge_load) begin
            pos.x    <= start_x;
            pos.z    <= start_z;
            pos.y_lo <= y_lo;
            pos.y_hi <= y_hi;
            step_x   <= fixed_t'(slope_x_w);
            step_z   <= fixed_t'(slope_z_w);
        end else if (edge_step) begin
            // Advance one row
            pos.x <= pos.x + step_x;
            pos.z <= pos.z + step_z;
        end
    end

endmodule

`default_nettype wire

// ==== logic/rast_pkg.sv ====
`default_nettype none

package rast_pkg;

    // Fixed-point format, 24 integer bits and 8 fraction bits
    localparam int FRAC_BITS = 8;

    typedef logic signed [31:0] fixed_t;

    // One whole pixel in fixed point
    localparam fixed_t ONE_PIXEL = 1 << FRAC_BITS;

    // Columns at or beyond this are clipped
    localparam int SCREEN_WIDTH = 640;

    // Credits granted by the pixel consumer after reset
    localparam int CREDITS_MAX = 4;

    // Vertex in screen space plus depth
    typedef struct packed {
        fixed_t x;
        fixed_t y;
        fixed_t z;
    } vertex_t;

    // Running edge position; y limits are already ceiled
    typedef struct packed {
        fixed_t x;
        fixed_t z;
        fixed_t y_lo;
        fixed_t y_hi;
    } edge_pos_t;

    // One row of the triangle, left edge first
    typedef struct packed {
        fixed_t y;
        fixed_t left_x;
        fixed_t left_z;
        fixed_t right_x;
        fixed_t right_z;
    } span_t;

    // Output pixel, x and y on whole-pixel boundaries
    typedef struct packed {
        fixed_t x;
        fixed_t y;
        fixed_t z;
    } pixel_t;

endpackage

`default_nettype wire

// ==== logic/scan_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module scan_ctrl import rast_pkg::*; (
    input  logic      CLK,
    input  logic      RESET,
    input  logic      start,
    input  logic      setup_ok,
    input  logic      culled,
    input  logic      span_done,
    input  edge_pos_t e_low,
    input  edge_pos_t e_high,
    input  edge_pos_t e_long,
    output logic      edge_load,
    output logic      step_low,
    output logic      step_high,
    output logic      step_long,
    output logic      span_go,
    output span_t     span,
    output logic      done
);

    typedef enum logic [3:0] {
        S_IDLE,
        S_SETUP,
        S_LOAD,
        S_LOW_INIT,
        S_LOW_ROW,
        S_LOW_WAIT,
        S_HIGH_INIT,
        S_HIGH_ROW,
        S_HIGH_WAIT,
        S_DONE
    } state_t;

    state_t state;
    fixed_t y_cnt;

    logic      in_high;
    edge_pos_t short_e, left_e, right_e;
    fixed_t    row_end;

    always_comb begin
        in_high = (state == S_HIGH_ROW) || (state == S_HIGH_WAIT);

        // Short edge pairs with the long edge in either half
        short_e = in_high ? e_high : e_low;
        row_end = in_high ? e_high.y_hi : e_low.y_hi;

        if (short_e.x <= e_long.x) begin
            left_e  = short_e;
            right_e = e_long;
        end else begin
            left_e  = e_long;
            right_e = short_e;
        end

        span.y       = y_cnt;
        span.left_x  = left_e.x;
        span.left_z  = left_e.z;
        span.right_x = right_e.x;
        span.right_z = right_e.z;

        edge_load = (state == S_LOAD);
        span_go   = ((state == S_LOW_ROW) || (state == S_HIGH_ROW)) && (y_cnt < row_end);
        step_low  = (state == S_LOW_WAIT) && span_done;
        step_high = (state == S_HIGH_WAIT) && span_done;
        step_long = step_low || step_high;
        done      = (state == S_DONE);
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state <= S_IDLE;
            y_cnt <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state <= S_SETUP;
                    end
                end
                S_SETUP: begin
                    if (culled) begin
                        state <= S_DONE;
                    end else if (setup_ok) begin
                        state <= S_LOAD;
                    end
                end
                S_LOAD:  state <= S_LOW_INIT;
                // Edge positions are valid here
                S_LOW_INIT: begin
                    y_cnt <= e_low.y_lo;
                    state <= S_LOW_ROW;
                end
                S_LOW_ROW: begin
                    state <= span_go ? S_LOW_WAIT : S_HIGH_INIT;
                end
                S_LOW_WAIT: begin
                    if (span_done) begin
                        y_cnt <= y_cnt + ONE_PIXEL;
                        state <= S_LOW_ROW;
                    end
                end
                S_HIGH_INIT: begin
                    y_cnt <= e_high.y_lo;
                    state <= S_HIGH_ROW;
                end
                S_HIGH_ROW: begin
                    state <= span_go ? S_HIGH_WAIT : S_DONE;
                end
                S_HIGH_WAIT: begin
                    if (span_done) begin
                        y_cnt <= y_cnt + ONE_PIXEL;
                        state <= S_HIGH_ROW;
                    end
                end
                S_DONE: begin
                    if (!start) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/span_walker.sv ====
`timescale 1ns/1ps
`default_nettype none

module span_walker import rast_pkg::*; (
    input  logic   CLK,
    input  logic   RESET,
    input  logic   span_go,
    input  span_t  span,
    input  logic   pixel_credit,
    output logic   pixel_valid,
    output pixel_t pixel,
    output logic   span_done
);

    logic running;
    logic [$clog2(CREDITS_MAX + 1)-1:0] credits;

    // Current pixel and row limits
    fixed_t cur_x, cur_y, cur_z, dz_dx, lim_x;

    // Span setup terms
    fixed_t start_x, start_z, end_x, next_x;
    logic signed [63:0] run_w, dz_w, slope_w, pre_w;

    always_comb begin
        start_x = (span.left_x + ONE_PIXEL - 1) & ~(ONE_PIXEL - 1);
        end_x   = (span.right_x < SCREEN_WIDTH * ONE_PIXEL) ?
                  span.right_x : SCREEN_WIDTH * ONE_PIXEL;

        run_w = 64'(span.right_x) - 64'(span.left_x);
        dz_w  = 64'(span.right_z) - 64'(span.left_z);
        if (run_w > 0) begin
            slope_w = (dz_w * ONE_PIXEL) / run_w;
        end else begin
            slope_w = '0;
        end

        // Depth at the first pixel centre
        pre_w   = (64'(start_x) - 64'(span.left_x)) * slope_w;
        start_z = span.left_z + fixed_t'(pre_w >>> FRAC_BITS);

        next_x = cur_x + ONE_PIXEL;
    end

    // A pixel goes out only while a credit is held
    assign pixel_valid = running && (credits != '0);
    assign pixel = '{x: cur_x, y: cur_y, z: cur_z};

    always_ff @(posedge CLK) begin
        if (RESET) begin
            running   <= 1'b0;
            span_done <= 1'b0;
            credits   <= $bits(credits)'(CREDITS_MAX);
        end else begin
            span_done <= 1'b0;
            if (span_go) begin
                if (start_x >= end_x) begin
                    span_done <= 1'b1;
                end else begin
                    running <= 1'b1;
                end
            end else if (pixel_valid && next_x >= lim_x) begin
                running   <= 1'b0;
                span_done <= 1'b1;
            end

            case ({pixel_credit, pixel_valid})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (span_go) begin
            cur_x <= start_x;
            cur_y <= span.y;
            cur_z <= start_z;
            dz_dx <= fixed_t'(slope_w);
            lim_x <= end_x;
        end else if (pixel_valid) begin
            cur_x <= next_x;
            cur_z <= cur_z + dz_dx;
        end
    end

endmodule

`default_nettype wire

// ==== logic/tri_raster.sv ====
`timescale 1ns/1ps
`default_nettype none

module tri_raster import rast_pkg::*; (
    input  logic    CLK,
    input  logic    RESET,
    input  logic    start,
    input  vertex_t v0,
    input  vertex_t v1,
    input  vertex_t v2,
    input  logic    pixel_credit,
    output logic    pixel_valid,
    output pixel_t  pixel,
    output logic    done
);

    vertex_t   sorted_bot, sorted_mid, sorted_top;
    logic      setup_ok, culled;
    logic      edge_load, step_low, step_high, step_long;
    edge_pos_t e_low, e_high, e_long;
    logic      span_go, span_done;
    span_t     span;

    tri_setup setup0 (
        .CLK        (CLK),
        .RESET      (RESET),
        .start      (start),
        .v0         (v0),
        .v1         (v1),
        .v2         (v2),
        .sorted_bot (sorted_bot),
        .sorted_mid (sorted_mid),
        .sorted_top (sorted_top),
        .setup_ok   (setup_ok),
        .culled     (culled)
    );

    // Lower half, bot to mid
    edge_walker edge_low0 (
        .CLK       (CLK),
        .RESET     (RESET),
        .edge_load (edge_load),
        .edge_step (step_low),
        .from_v    (sorted_bot),
        .to_v      (sorted_mid),
        .pos       (e_low)
    );

    // Upper half, mid to top
    edge_walker edge_high0 (
        .CLK       (CLK),
        .RESET     (RESET),
        .edge_load (edge_load),
        .edge_step (step_high),
        .from_v    (sorted_mid),
        .to_v      (sorted_top),
        .pos       (e_high)
    );

    // Long edge spans both halves
    edge_walker edge_long0 (
        .CLK       (CLK),
        .RESET     (RESET),
        .edge_load (edge_load),
        .edge_step (step_long),
        .from_v    (sorted_bot),
        .to_v      (sorted_top),
        .pos       (e_long)
    );

    scan_ctrl ctrl0 (
        .CLK       (CLK),
        .RESET     (RESET),
        .start     (start),
        .setup_ok  (setup_ok),
        .culled    (culled),
        .span_done (span_done),
        .e_low     (e_low),
        .e_high    (e_high),
        .e_long    (e_long),
        .edge_load (edge_load),
        .step_low  (step_low),
        .step_high (step_high),
        .step_long (step_long),
        .span_go   (span_go),
        .span      (span),
        .done      (done)
    );

    span_walker span0 (
        .CLK          (CLK),
        .RESET        (RESET),
        .span_go      (span_go),
        .span         (span),
        .pixel_credit (pixel_credit),
        .pixel_valid  (pixel_valid),
        .pixel        (pixel),
        .span_done    (span_done)
    );

endmodule

`default_nettype wire

// ==== logic/tri_setup.sv ====
`timescale 1ns/1ps
`default_nettype none

module tri_setup import rast_pkg::*; (
    input  logic    CLK,
    input  logic    RESET,
    input  logic    start,
    input  vertex_t v0,
    input  vertex_t v1,
    input  vertex_t v2,
    output vertex_t sorted_bot,
    output vertex_t sorted_mid,
    output vertex_t sorted_top,
    output logic    setup_ok,
    output logic    culled
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_CALC,
        S_HOLD
    } state_t;

    state_t state;

    // Vertices captured on start
    vertex_t va, vb, vc;

    // Sort network
    vertex_t lo, md, hi, swap_v;

    // Edge vectors, normal and facing term
    logic signed [32:0]  e1x, e1y, e1z;
    logic signed [32:0]  e2x, e2y, e2z;
    logic signed [66:0]  nx, ny, nz;
    logic signed [101:0] facing;

    always_comb begin
        swap_v = va;
        lo = va;
        md = vb;
        hi = vc;
        if (lo.y > md.y) begin
            swap_v = lo;
            lo = md;
            md = swap_v;
        end
        if (md.y > hi.y) begin
            swap_v = md;
            md = hi;
            hi = swap_v;
        end
        if (lo.y > md.y) begin
            swap_v = lo;
            lo = md;
            md = swap_v;
        end
    end

    // Normal is (v1 - v0) x (v2 - v0), kept at full width
    always_comb begin
        e1x = vb.x - va.x;
        e1y = vb.y - va.y;
        e1z = vb.z - va.z;
        e2x = vc.x - va.x;
        e2y = vc.y - va.y;
        e2z = vc.z - va.z;
        nx = e1y * e2z - e1z * e2y;
        ny = e1z * e2x - e1x * e2z;
        nz = e1x * e2y - e1y * e2x;
        facing = va.x * nx + va.y * ny + va.z * nz;
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state    <= S_IDLE;
            setup_ok <= 1'b0;
            culled   <= 1'b0;
        end else begin
            setup_ok <= 1'b0;
            culled   <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state <= S_CALC;
                    end
                end
                S_CALC: begin
                    // Facing away from the eye when the dot is non-negative
                    culled   <= (facing >= 0);
                    setup_ok <= (facing < 0);
                    state    <= S_HOLD;
                end
                S_HOLD: begin
                    if (!start) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (state == S_IDLE && start) begin
            va <= v0;
            vb <= v1;
            vc <= v2;
        end
        if (state == S_CALC) begin
            sorted_bot <= lo;
            sorted_mid <= md;
            sorted_top <= hi;
        end
    end

endmodule

`default_nettype wire

// ==== tests/tri_vectors.svh ====
`ifndef TRI_VECTORS_SVH
`define TRI_VECTORS_SVH

// One table row: name, three vertices, credit hold, expected cull and pixel count
typedef struct {
    string   name;
    vertex_t v0;
    vertex_t v1;
    vertex_t v2;
    bit      hold;
    logic    culled;
    int      count;
} tri_case_t;

tri_case_t cases[$];

function automatic longint ceil_px(longint a);
    return ((a + ONE_PIXEL - 1) >>> FRAC_BITS) <<< FRAC_BITS;
endfunction

// Vertex from whole-pixel coordinates
function automatic vertex_t vtx(int x, int y, int z);
    vertex_t v;
    v.x = x * ONE_PIXEL;
    v.y = y * ONE_PIXEL;
    v.z = z * ONE_PIXEL;
    return v;
endfunction

// Moves x and y up by half a pixel
function automatic vertex_t half_up(vertex_t v);
    v.x = v.x + ONE_PIXEL / 2;
    v.y = v.y + ONE_PIXEL / 2;
    return v;
endfunction

// Back face when the normal points along the eye ray to v0
function automatic logic faces_away(vertex_t a, vertex_t b, vertex_t c);
    longint ux, uy, uz, wx, wy, wz, nx, ny, nz;
    ux = longint'(b.x) - a.x;
    uy = longint'(b.y) - a.y;
    uz = longint'(b.z) - a.z;
    wx = longint'(c.x) - a.x;
    wy = longint'(c.y) - a.y;
    wz = longint'(c.z) - a.z;
    nx = uy * wz - uz * wy;
    ny = uz * wx - ux * wz;
    nz = ux * wy - uy * wx;
    return (nx * a.x + ny * a.y + nz * a.z) >= 0;
endfunction

// Edge x at row y, straight line between p and q
function automatic longint edge_x_at(vertex_t p, vertex_t q, longint y);
    return longint'(p.x) + ((y - p.y) * (longint'(q.x) - p.x)) / (longint'(q.y) - p.y);
endfunction

function automatic int ref_pixel_count(vertex_t a, vertex_t b, vertex_t c);
    vertex_t lo, md, hi, t;
    longint  y, x, xl, xs, left, right;
    int      n;
    lo = a;
    md = b;
    hi = c;
    if (md.y < lo.y) begin
        t = lo;
        lo = md;
        md = t;
    end
    if (hi.y < md.y) begin
        t = md;
        md = hi;
        hi = t;
    end
    if (md.y < lo.y) begin
        t = lo;
        lo = md;
        md = t;
    end
    n = 0;
    for (y = ceil_px(lo.y); y < ceil_px(hi.y); y = y + ONE_PIXEL) begin
        xl = edge_x_at(lo, hi, y);
        xs = (y < ceil_px(md.y)) ? edge_x_at(lo, md, y) : edge_x_at(md, hi, y);
        left = (xl < xs) ? xl : xs;
        right = (xl < xs) ? xs : xl;
        // Columns from ceil(left) up to right, clipped at the screen edge
        for (x = ceil_px(left); x < right && x < SCREEN_WIDTH * ONE_PIXEL; x = x + ONE_PIXEL) begin
            n = n + 1;
        end
    end
    return n;
endfunction

function automatic void add_case(string name, vertex_t a, vertex_t b, vertex_t c, bit hold);
    tri_case_t tc;
    tc.name = name;
    tc.v0 = a;
    tc.v1 = b;
    tc.v2 = c;
    tc.hold = hold;
    tc.culled = faces_away(a, b, c);
    tc.count = tc.culled ? 0 : ref_pixel_count(a, b, c);
    cases.push_back(tc);
endfunction

task automatic build_cases();
    vertex_t pb, pm, pt;
    pb = vtx(100, 50, 40);
    pm = vtx(164, 82, 72);
    pt = vtx(120, 114, 56);
    add_case("flat_bottom", vtx(10, 10, 20), vtx(20, 30, 20), vtx(30, 10, 20), 0);
    add_case("back_face", vtx(10, 10, 20), vtx(30, 10, 20), vtx(20, 30, 20), 0);
    // All six orderings of one sloped triangle
    add_case("perm_bmt", pb, pm, pt, 0);
    add_case("perm_mtb", pm, pt, pb, 0);
    add_case("perm_tbm", pt, pb, pm, 0);
    add_case("perm_btm", pb, pt, pm, 0);
    add_case("perm_tmb", pt, pm, pb, 0);
    add_case("perm_mbt", pm, pb, pt, 0);
    add_case("flat_top", vtx(400, 300, 25), vtx(440, 300, 25), vtx(420, 260, 25), 0);
    add_case("half_pixel", half_up(vtx(200, 100, 30)), half_up(vtx(210, 120, 30)),
             half_up(vtx(220, 100, 30)), 0);
    add_case("screen_clip", vtx(610, 10, 20), vtx(650, 50, 20), vtx(690, 10, 20), 0);
    add_case("credit_hold", vtx(300, 200, 50), vtx(320, 240, 50), vtx(340, 200, 50), 1);
endtask

`endif

// ==== tests/tb_tri_raster.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_tri_raster import rast_pkg::*; ();

    `include "tri_vectors.svh"

    logic    CLK;
    logic    RESET;
    logic    start;
    vertex_t v0, v1, v2;
    logic    pixel_credit;
    logic    pixel_valid;
    pixel_t  pixel;
    logic    done;

    tri_case_t cur;
    bit        hold_credits;
    int        error_count;
    int        limit_cycles;
    int        pix_count;
    int        owed;
    int        sent;
    int        returned;
    int        row_len;
    fixed_t    row_dz;
    pixel_t    last_pix;
    longint    y_first, y_last;

    tri_raster dut0 (
        .CLK          (CLK),
        .RESET        (RESET),
        .start        (start),
        .v0           (v0),
        .v1           (v1),
        .v2           (v2),
        .pixel_credit (pixel_credit),
        .pixel_valid  (pixel_valid),
        .pixel        (pixel),
        .done         (done)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    task automatic stop_run();
        error_count = error_count + 1;
        $display("Done: errors found");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_pixel(input string name, input pixel_t exp, input pixel_t act);
        if (act !== exp) begin
            $display("[FAIL] %s expected x=%h y=%h z=%h actual x=%h y=%h z=%h",
                     name, exp.x, exp.y, exp.z, act.x, act.y, act.z);
            stop_run();
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %0d actual %0d", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %b actual %b", name, exp, act);
            stop_run();
        end
    endtask

    // Grid, range and in-row order of one pixel
    task automatic inspect_pixel(input pixel_t p);
        pixel_t want;
        check_flag({cur.name, " on grid"}, 1'b1,
                   p.x[FRAC_BITS-1:0] == 0 && p.y[FRAC_BITS-1:0] == 0);
        check_flag({cur.name, " row in range"}, 1'b1, p.y >= y_first && p.y < y_last);
        check_flag({cur.name, " inside screen"}, 1'b1, p.x < SCREEN_WIDTH * ONE_PIXEL);
        if (row_len > 0) begin
            check_flag({cur.name, " rows ascending"}, 1'b1, p.y >= last_pix.y);
        end
        if (row_len > 0 && p.y == last_pix.y) begin
            want.x = last_pix.x + ONE_PIXEL;
            want.y = last_pix.y;
            // Depth step is known from the second pixel on
            want.z = (row_len > 1) ? last_pix.z + row_dz : p.z;
            check_pixel({cur.name, " row step"}, want, p);
            row_dz = p.z - last_pix.z;
            row_len = row_len + 1;
        end else begin
            row_len = 1;
        end
        last_pix = p;
    endtask

    // Pixel monitor and credit balance
    always @(posedge CLK) begin
        if (!RESET && pixel_valid) begin
            sent = sent + 1;
            check_flag("credit balance", 1'b1, sent <= CREDITS_MAX + returned);
            pix_count = pix_count + 1;
            owed = owed + 1;
            inspect_pixel(pixel);
        end
        if (!RESET && pixel_credit) begin
            returned = returned + 1;
        end
    end

    // Consumer returns one credit per pixel after a random delay
    initial begin
        int delay;
        pixel_credit = 1'b0;
        void'($urandom(32'hb08a69ea));
        forever begin
            @(negedge CLK);
            pixel_credit = 1'b0;
            if (owed > 0 && !hold_credits) begin
                delay = $urandom % 4;
                repeat (delay) @(negedge CLK);
                pixel_credit = 1'b1;
                owed = owed - 1;
            end
        end
    end

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge CLK);
        $display("Watchdog expired: the table did not finish within %0d cycles", limit_cycles);
        stop_run();
    end

    task automatic run_case(input tri_case_t tc);
        cur = tc;
        y_first = ceil_px(tc.v0.y);
        y_last = y_first;
        if (ceil_px(tc.v1.y) < y_first) begin
            y_first = ceil_px(tc.v1.y);
        end
        if (ceil_px(tc.v2.y) < y_first) begin
            y_first = ceil_px(tc.v2.y);
        end
        if (ceil_px(tc.v1.y) > y_last) begin
            y_last = ceil_px(tc.v1.y);
        end
        if (ceil_px(tc.v2.y) > y_last) begin
            y_last = ceil_px(tc.v2.y);
        end
        @(negedge CLK);
        pix_count = 0;
        row_len = 0;
        hold_credits = tc.hold;
        v0 = tc.v0;
        v1 = tc.v1;
        v2 = tc.v2;
        start = 1'b1;
        if (tc.hold) begin
            // Only the initial credits may be spent while none come back
            repeat (30) @(negedge CLK);
            check_count({tc.name, " while held"}, CREDITS_MAX, pix_count);
            hold_credits = 1'b0;
        end
        while (!done) @(negedge CLK);
        start = 1'b0;
        check_flag({tc.name, " culled"}, tc.culled, pix_count == 0);
        check_count({tc.name, " pixel count"}, tc.count, pix_count);
        while (owed != 0) @(negedge CLK);
        repeat (2) @(negedge CLK);
    endtask

    initial begin
        RESET = 1'b1;
        start = 1'b0;
        v0 = '0;
        v1 = '0;
        v2 = '0;
        hold_credits = 1'b0;
        error_count = 0;
        pix_count = 0;
        owed = 0;
        sent = 0;
        returned = 0;
        row_len = 0;
        build_cases();
        for (int i = 0; i < cases.size(); i++) begin
            limit_cycles = limit_cycles + 20 + 8 * cases[i].count;
        end
        repeat (10) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;
        for (int i = 0; i < cases.size(); i++) begin
            run_case(cases[i]);
        end
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+tests
logic/rast_pkg.sv
logic/tri_setup.sv
logic/edge_walker.sv
logic/span_walker.sv
logic/scan_ctrl.sv
logic/tri_raster.sv
tests/tb_tri_raster.sv
